// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    localparam int wordW   = 16;             // Data and instruction width
    localparam int regIdxW = 3;              // Eight architectural registers
    localparam int opW     = 5;              // Opcode field, bits 15..11
    localparam int functW  = 2;              // R-format funct, bits 1..0
    localparam int immW    = 5;              // I-format immediate

    // Primary opcodes
    localparam logic [opW-1:0] opHalt  = 5'b00000;
    localparam logic [opW-1:0] opNop   = 5'b00001;
    localparam logic [opW-1:0] opAddi  = 5'b01000;
    localparam logic [opW-1:0] opBeqz  = 5'b01100;
    localparam logic [opW-1:0] opSt    = 5'b10000;
    localparam logic [opW-1:0] opLd    = 5'b10001;
    localparam logic [opW-1:0] opRType = 5'b11011;

    // R-format ALU functions
    localparam logic [functW-1:0] fnAdd  = 2'b00;
    localparam logic [functW-1:0] fnSub  = 2'b01;   // rs - rt
    localparam logic [functW-1:0] fnXor  = 2'b10;
    localparam logic [functW-1:0] fnAndn = 2'b11;   // rs & ~rt

    // One instruction word, two field layouts.
    // rs sits in bits 10..8 in both views
    typedef union packed {
        struct packed {
            logic [opW-1:0]     opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rt;              // Bits 7..5
            logic [regIdxW-1:0] rd;              // Bits 4..2
            logic [functW-1:0]  funct;
        } r;
        struct packed {
            logic [opW-1:0]     opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rd;              // Dest, or data reg for ST
            logic [immW-1:0]    imm5;            // Sign-extended in decode
        } i;
    } instrU;

endpackage

// ==== rtl/regFile.sv ====
module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [cpuPkg::regIdxW-1:0] rdAddrA,
    input  logic [cpuPkg::regIdxW-1:0] rdAddrB,
    input  logic                       we,
    input  logic [cpuPkg::regIdxW-1:0] wrAddr,
    input  logic [cpuPkg::wordW-1:0]   wrData,
    output logic [cpuPkg::wordW-1:0]   rdDataA,
    output logic [cpuPkg::wordW-1:0]   rdDataB
);
    import cpuPkg::*;

    localparam int numRegs = 2 ** regIdxW;

    logic [wordW-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < numRegs; k++) begin
                regs[k] <= '0;                       // All cleared
            end
        end else if (we) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through, writeback value seen by decode the same cycle
    assign rdDataA = (we && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
    assign rdDataB = (we && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

// ==== rtl/fetchStage.sv ====
module fetchStage #(
    parameter int imemDepth = 256
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     imemWe,          // Load port, used during reset
    input  logic [cpuPkg::wordW-1:0] imemAddr,
    input  logic [cpuPkg::wordW-1:0] imemData,
    input  logic                     stall,           // From decode hazard check
    input  logic                     flush,           // Taken branch in execute
    input  logic [cpuPkg::wordW-1:0] branchTarget,
    input  logic                     haltSeen,        // HALT decoded, freeze
    output logic                     ifValid,
    output cpuPkg::instrU            ifInstr,
    output logic [cpuPkg::wordW-1:0] ifPc
);
    import cpuPkg::*;

    localparam int imemAw = $clog2(imemDepth);

    logic [wordW-1:0] imem [imemDepth];              // Word addressed
    logic [wordW-1:0] pc;

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[imemAw-1:0]] <= imemData;  // Low bits, modulo depth
        end
    end

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            ifValid <= 1'b0;
        end else if (flush) begin
            pc      <= branchTarget;                 // Redirect wins over hold
            ifValid <= 1'b0;                         // Kill wrong-path word
        end else if (!(stall || haltSeen)) begin
            pc      <= pc + wordW'(1);
            ifValid <= 1'b1;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!(stall || haltSeen)) begin
            ifInstr <= imem[pc[imemAw-1:0]];         // Single-cycle read
            ifPc    <= pc;
        end
    end

    // Once HALT is decoded the PC must not move unless an older branch redirects
    pcFrozenOnHalt: assert property (@(posedge clk) disable iff (!rstN)
        haltSeen && !flush |=> $stable(pc));

endmodule

// ==== rtl/decodeStage.sv ====
module decodeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       ifValid,
    input  cpuPkg::instrU              ifInstr,
    input  logic [cpuPkg::wordW-1:0]   ifPc,
    input  logic                       flush,
    input  logic [cpuPkg::regIdxW-1:0] exDest,        // Instr now in execute
    input  logic                       exWrites,
    input  logic [cpuPkg::regIdxW-1:0] memDest,       // Instr now in memory
    input  logic                       memWrites,
    input  logic                       wbWe,
    input  logic [cpuPkg::regIdxW-1:0] wbReg,
    input  logic [cpuPkg::wordW-1:0]   wbData,
    output logic                       stall,
    output logic                       haltSeen,
    output logic                       idValid,
    output logic [cpuPkg::wordW-1:0]   idA,
    output logic [cpuPkg::wordW-1:0]   idB,           // rt, ADDI imm, or ST data
    output logic [cpuPkg::wordW-1:0]   idImm,
    output logic [cpuPkg::wordW-1:0]   idPc,
    output logic [cpuPkg::regIdxW-1:0] idDest,
    output logic                       idWrites,
    output logic                       idLoad,
    output logic                       idStore,
    output logic                       idBranch,
    output logic [cpuPkg::functW-1:0]  idFunct,
    output logic                       idHalt,
    output logic                       err             // Sticky illegal opcode
);
    import cpuPkg::*;

    logic [opW-1:0]     op;
    logic               isRType, isAddi, isLd, isSt, isBeqz, isHalt, isNop, legal;
    logic               usesA, usesB, writes, hazA, hazB, haltReg, issue;
    logic [regIdxW-1:0] srcA, srcB, dest;
    logic [wordW-1:0]   rfA, rfB, extImm;

    assign op      = ifInstr.r.opcode;
    assign isRType = (op == opRType);
    assign isAddi  = (op == opAddi);
    assign isLd    = (op == opLd);
    assign isSt    = (op == opSt);
    assign isBeqz  = (op == opBeqz);
    assign isHalt  = (op == opHalt);
    assign isNop   = (op == opNop);
    assign legal   = isRType | isAddi | isLd | isSt | isBeqz | isHalt | isNop;

    assign srcA   = ifInstr.r.rs;                           // Same bits in both views
    assign srcB   = isSt ? ifInstr.i.rd : ifInstr.r.rt;     // ST data in rd field
    assign dest   = isRType ? ifInstr.r.rd : ifInstr.i.rd;
    assign usesA  = isRType | isAddi | isLd | isSt | isBeqz;
    assign usesB  = isRType | isSt;
    assign writes = isRType | isAddi | isLd;
    assign extImm = {{(wordW-immW){ifInstr.i.imm5[immW-1]}}, ifInstr.i.imm5};

    regFile rf (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (srcA),
        .rdAddrB (srcB),
        .we      (wbWe),
        .wrAddr  (wbReg),
        .wrData  (wbData),
        .rdDataA (rfA),
        .rdDataB (rfB)
    );

    // Interlock, no forwarding. Writeback needs no check, regFile writes through
    assign hazA  = usesA && ((exWrites && (exDest == srcA)) || (memWrites && (memDest == srcA)));
    assign hazB  = usesB && ((exWrites && (exDest == srcB)) || (memWrites && (memDest == srcB)));
    assign stall = ifValid && !haltReg && (hazA || hazB);

    assign issue    = ifValid && !haltReg && !stall && !flush;
    assign haltSeen = haltReg || (ifValid && isHalt);       // Fetch freezes this cycle

    // ID/EX control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idValid  <= 1'b0;
            idWrites <= 1'b0;
            idLoad   <= 1'b0;
            idStore  <= 1'b0;
            idBranch <= 1'b0;
            idHalt   <= 1'b0;
            haltReg  <= 1'b0;
            err      <= 1'b0;
        end else begin
            idValid  <= issue;                       // Bubble on stall or flush
            idWrites <= issue && writes;
            idLoad   <= issue && isLd;
            idStore  <= issue && isSt;
            idBranch <= issue && isBeqz;
            idHalt   <= issue && isHalt;
            haltReg  <= haltReg || (issue && isHalt);
            err      <= err || (issue && !legal);    // Illegal goes on as NOP
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        idA     <= rfA;
        idB     <= isAddi ? extImm : rfB;            // ADDI takes the ALU B slot
        idImm   <= extImm;
        idPc    <= ifPc;
        idDest  <= dest;
        idFunct <= isRType ? ifInstr.r.funct : fnAdd;
    end

    // Nothing younger than a HALT in execute may still be waiting on a stall
    noStallBehindHalt: assert property (@(posedge clk) disable iff (!rstN)
        !(stall && idValid && idHalt));

    errSticky: assert property (@(posedge clk)
        err && rstN |=> err);

endmodule

// ==== rtl/executeStage.sv ====
module executeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       idValid,
    input  logic [cpuPkg::wordW-1:0]   idA,
    input  logic [cpuPkg::wordW-1:0]   idB,
    input  logic [cpuPkg::wordW-1:0]   idImm,
    input  logic [cpuPkg::wordW-1:0]   idPc,
    input  logic [cpuPkg::regIdxW-1:0] idDest,
    input  logic                       idWrites,
    input  logic                       idLoad,
    input  logic                       idStore,
    input  logic                       idBranch,
    input  logic [cpuPkg::functW-1:0]  idFunct,
    input  logic                       idHalt,
    output logic                       flush,          // Taken BEQZ
    output logic [cpuPkg::wordW-1:0]   branchTarget,
    output logic [cpuPkg::regIdxW-1:0] exDest,         // Hazard view of this stage
    output logic                       exWrites,
    output logic                       exValid,
    output logic [cpuPkg::wordW-1:0]   exResult,       // ALU result or address
    output logic [cpuPkg::wordW-1:0]   exStoreData,
    output logic                       exLoad,
    output logic                       exStore,
    output logic                       exHalt
);
    import cpuPkg::*;

    logic [wordW-1:0] aluOut, addr;

    always_comb begin
        case (idFunct)
            fnAdd:   aluOut = idA + idB;             // ADD and ADDI
            fnSub:   aluOut = idA - idB;
            fnXor:   aluOut = idA ^ idB;
            default: aluOut = idA & ~idB;            // ANDN
        endcase
    end

    assign addr = idA + idImm;                       // LD and ST

    // BEQZ resolves here, target is PC + 1 + imm
    assign flush        = idValid && idBranch && (idA == '0);
    assign branchTarget = idPc + wordW'(1) + idImm;

    assign exDest   = idDest;
    assign exWrites = idValid && idWrites;

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
            exLoad  <= 1'b0;
            exStore <= 1'b0;
            exHalt  <= 1'b0;
        end else begin
            exValid <= idValid;
            exLoad  <= idValid && idLoad;
            exStore <= idValid && idStore;
            exHalt  <= idValid && idHalt;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        exResult    <= (idLoad || idStore) ? addr : aluOut;
        exStoreData <= idB;
    end

    // A redirect comes only from a real branch and leaves a bubble behind it
    flushFromBranch: assert property (@(posedge clk) disable iff (!rstN)
        flush |-> (idValid && idBranch) ##1 !idValid);

endmodule

// ==== rtl/memoryStage.sv ====
module memoryStage #(
    parameter int dmemDepth = 256
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       exValid,
    input  logic [cpuPkg::wordW-1:0]   exResult,
    input  logic [cpuPkg::wordW-1:0]   exStoreData,
    input  logic                       exLoad,
    input  logic                       exStore,
    input  logic [cpuPkg::regIdxW-1:0] exDest,
    input  logic                       exWrites,
    input  logic                       exHalt,
    output logic [cpuPkg::regIdxW-1:0] memDest,        // Dest of instr in this stage
    output logic                       memWrites,
    output logic                       stValid,
    output logic [cpuPkg::wordW-1:0]   stAddr,
    output logic [cpuPkg::wordW-1:0]   stData,
    output logic                       wbWe,
    output logic [cpuPkg::regIdxW-1:0] wbReg,
    output logic [cpuPkg::wordW-1:0]   wbData,
    output logic                       wbHalt          // Sticky once HALT retires
);
    import cpuPkg::*;

    localparam int dmemAw = $clog2(dmemDepth);

    logic [wordW-1:0]  dmem [dmemDepth];
    logic [dmemAw-1:0] dAddr;
    logic [wordW-1:0]  loadData;

    assign dAddr    = exResult[dmemAw-1:0];          // Modulo depth
    assign loadData = dmem[dAddr];                   // Single-cycle read

    always_ff @(posedge clk) begin
        if (stValid) begin
            dmem[dAddr] <= exStoreData;
        end
    end

    // Store report, same cycle as the write
    assign stValid = exValid && exStore;
    assign stAddr  = exResult;
    assign stData  = exStoreData;

    // Dest tracking and MEM/WB control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWrites <= 1'b0;
            wbWe      <= 1'b0;
            wbHalt    <= 1'b0;
        end else begin
            memWrites <= exWrites;
            wbWe      <= memWrites;
            wbHalt    <= wbHalt || exHalt;
        end
    end

    always_ff @(posedge clk) begin
        memDest <= exDest;
        wbReg   <= memDest;
        wbData  <= exLoad ? loadData : exResult;     // Load data or ALU result
    end

    loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(exLoad && exStore));

endmodule

// ==== rtl/proc.sv ====
module proc #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       imemWe,
    input  logic [cpuPkg::wordW-1:0]   imemAddr,
    input  logic [cpuPkg::wordW-1:0]   imemData,
    output logic                       wbValid,      // One pulse per register write
    output logic [cpuPkg::regIdxW-1:0] wbReg,
    output logic [cpuPkg::wordW-1:0]   wbData,
    output logic                       stValid,      // One pulse per store
    output logic [cpuPkg::wordW-1:0]   stAddr,
    output logic [cpuPkg::wordW-1:0]   stData,
    output logic                       halted,
    output logic                       err
);
    import cpuPkg::*;

    // IF/ID
    logic               ifValid;
    instrU              ifInstr;
    logic [wordW-1:0]   ifPc;
    // Backward paths
    logic               stall, flush, haltSeen;
    logic [wordW-1:0]   branchTarget;
    // ID/EX
    logic               idValid, idWrites, idLoad, idStore, idBranch, idHalt;
    logic [wordW-1:0]   idA, idB, idImm, idPc;
    logic [regIdxW-1:0] idDest;
    logic [functW-1:0]  idFunct;
    // EX/MEM and hazard tracking
    logic               exValid, exWrites, exLoad, exStore, exHalt;
    logic [wordW-1:0]   exResult, exStoreData;
    logic [regIdxW-1:0] exDest, memDest;
    logic               memWrites, wbWe, wbHalt;

    fetchStage #(.imemDepth(imemDepth)) fetch (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .flush(flush), .branchTarget(branchTarget), .haltSeen(haltSeen),
        .ifValid(ifValid), .ifInstr(ifInstr), .ifPc(ifPc)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN),
        .ifValid(ifValid), .ifInstr(ifInstr), .ifPc(ifPc), .flush(flush),
        .exDest(exDest), .exWrites(exWrites), .memDest(memDest), .memWrites(memWrites),
        .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData),
        .stall(stall), .haltSeen(haltSeen),
        .idValid(idValid), .idA(idA), .idB(idB), .idImm(idImm), .idPc(idPc),
        .idDest(idDest), .idWrites(idWrites), .idLoad(idLoad), .idStore(idStore),
        .idBranch(idBranch), .idFunct(idFunct), .idHalt(idHalt), .err(err)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .idValid(idValid), .idA(idA), .idB(idB), .idImm(idImm), .idPc(idPc),
        .idDest(idDest), .idWrites(idWrites), .idLoad(idLoad), .idStore(idStore),
        .idBranch(idBranch), .idFunct(idFunct), .idHalt(idHalt),
        .flush(flush), .branchTarget(branchTarget), .exDest(exDest), .exWrites(exWrites),
        .exValid(exValid), .exResult(exResult), .exStoreData(exStoreData),
        .exLoad(exLoad), .exStore(exStore), .exHalt(exHalt)
    );

    memoryStage #(.dmemDepth(dmemDepth)) memory (
        .clk(clk), .rstN(rstN),
        .exValid(exValid), .exResult(exResult), .exStoreData(exStoreData),
        .exLoad(exLoad), .exStore(exStore), .exDest(exDest), .exWrites(exWrites),
        .exHalt(exHalt),
        .memDest(memDest), .memWrites(memWrites),
        .stValid(stValid), .stAddr(stAddr), .stData(stData),
        .wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .wbHalt(wbHalt)
    );

    assign wbValid = wbWe;                           // Writeback stage is only the port
    assign halted  = wbHalt;

endmodule

// ==== verification/clockGen.sv ====
module clockGen #(
    parameter int period = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;                 // Free running, 50% duty

endmodule

// ==== verification/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [wordW-1:0]   progMem [imemDepth];             // Program image, loader and model
int                 progLen;
logic [wordW-1:0]   modelMem [dmemDepth];            // Kept across programs, like dmem
logic [regIdxW-1:0] expWrIdx [$];                    // Expected writes in program order
logic [wordW-1:0]   expWrVal [$];
logic [wordW-1:0]   expStAddr [$];                   // Expected stores in program order
logic [wordW-1:0]   expStData [$];
logic               expHalt;
logic               expErr;

// Sequential ISA run of progMem, returns the number of executed instructions
function automatic int runModel(input int maxSteps);
    instrU            ins;
    logic [wordW-1:0] regs [8];
    logic [wordW-1:0] pc, a, b, imm, addr, res;
    logic [regIdxW-1:0] wrIdx;
    logic             wr;
    int               steps;
    for (int k = 0; k < 8; k++) regs[k] = '0;
    expWrIdx.delete();
    expWrVal.delete();
    expStAddr.delete();
    expStData.delete();
    expHalt = 1'b0;
    expErr  = 1'b0;
    pc      = '0;
    steps   = 0;
    while (!expHalt && steps < maxSteps) begin
        ins   = progMem[int'(pc) % imemDepth];
        a     = regs[ins.r.rs];
        b     = regs[ins.r.rt];
        imm   = wordW'($signed(ins.i.imm5));         // 5-bit two's complement
        addr  = a + imm;
        pc    = pc + 1'b1;                           // Branches are relative to this
        wr    = 1'b0;
        wrIdx = ins.i.rd;
        res   = '0;
        steps++;
        case (ins.r.opcode)
            opHalt:  expHalt = 1'b1;
            opNop:   wr = 1'b0;
            opAddi: begin
                wr  = 1'b1;
                res = a + imm;
            end
            opRType: begin
                wr    = 1'b1;
                wrIdx = ins.r.rd;
                case (ins.r.funct)
                    fnAdd:  res = a + b;
                    fnSub:  res = a - b;                 // rs minus rt
                    fnXor:  res = a ^ b;
                    fnAndn: res = a & ~b;                // rs and not rt
                endcase
            end
            opLd: begin
                wr  = 1'b1;
                res = modelMem[int'(addr) % dmemDepth];
            end
            opSt: begin
                modelMem[int'(addr) % dmemDepth] = regs[ins.i.rd];
                expStAddr.push_back(addr);           // Full address on the port
                expStData.push_back(regs[ins.i.rd]);
            end
            opBeqz:  if (a == '0) pc = pc + imm;
            default: expErr = 1'b1;                  // Retires as a NOP
        endcase
        if (wr) begin
            regs[wrIdx] = res;
            expWrIdx.push_back(wrIdx);
            expWrVal.push_back(res);
        end
    end
    return steps;
endfunction

`endif

// ==== verification/tbProc.sv ====
module tbProc;
    import cpuPkg::*;

    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;

    logic               clk, rstN, imemWe;
    logic [wordW-1:0]   imemAddr, imemData;
    logic               wbValid, stValid, halted, err;
    logic [regIdxW-1:0] wbReg;
    logic [wordW-1:0]   wbData, stAddr, stData;
    logic               checking;                    // Monitor armed from reset release to end check

    `include "isaModel.svh"

    clockGen #(.period(100)) clkGen (.clk(clk));

    proc #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) uut (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .stValid(stValid), .stAddr(stAddr), .stData(stData), .halted(halted), .err(err)
    );

    task automatic reportFail();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkRegWrite(input logic [regIdxW-1:0] idx, input logic [wordW-1:0] value);
        logic [regIdxW-1:0] expIdx;
        logic [wordW-1:0]   expVal;
        if (expWrIdx.size() == 0) begin
            $display("Register write to r%0d at time %0t that the model never makes", idx, $time);
            reportFail();
        end else begin
            expIdx = expWrIdx.pop_front();
            expVal = expWrVal.pop_front();
            if (idx !== expIdx) begin
                $display("Mismatch at time %0t: wbReg expected %0d got %0d", $time, expIdx, idx);
                reportFail();
            end else if (value !== expVal) begin
                $display("Mismatch at time %0t: wbData expected %h got %h", $time, expVal, value);
                reportFail();
            end
        end
    endtask

    task automatic checkStore(input logic [wordW-1:0] addr, input logic [wordW-1:0] data);
        logic [wordW-1:0] expAddr;
        logic [wordW-1:0] expData;
        if (expStAddr.size() == 0) begin
            $display("Store to %h at time %0t that the model never makes", addr, $time);
            reportFail();
        end else begin
            expAddr = expStAddr.pop_front();
            expData = expStData.pop_front();
            if (addr !== expAddr) begin
                $display("Mismatch at time %0t: stAddr expected %h got %h", $time, expAddr, addr);
                reportFail();
            end else if (data !== expData) begin
                $display("Mismatch at time %0t: stData expected %h got %h", $time, expData, data);
                reportFail();
            end
        end
    endtask

    task automatic checkEnd(input string name, input logic haltedNow, input logic errNow);
        if (expWrIdx.size() != 0 || expStAddr.size() != 0) begin
            $display("%s: %0d register writes and %0d stores never appeared", name,
                     expWrIdx.size(), expStAddr.size());
            reportFail();
        end else if (haltedNow !== expHalt) begin
            $display("Mismatch at time %0t: halted expected %b got %b", $time, expHalt, haltedNow);
            reportFail();
        end else if (errNow !== expErr) begin
            $display("Mismatch at time %0t: err expected %b got %b", $time, expErr, errNow);
            reportFail();
        end
    endtask

    function automatic logic [wordW-1:0] encodeR(input int rs, input int rt, input int rd,
                                                 input logic [functW-1:0] fn);
        return {opRType, regIdxW'(rs), regIdxW'(rt), regIdxW'(rd), fn};
    endfunction

    function automatic logic [wordW-1:0] encodeI(input logic [opW-1:0] op, input int rs,
                                                 input int rd, input int imm);
        return {op, regIdxW'(rs), regIdxW'(rd), immW'(imm)};  // rd is ST data register
    endfunction

    function automatic void emit(input logic [wordW-1:0] word);
        progMem[progLen] = word;
        progLen++;
    endfunction

    // ADDI chain to seed all registers, then random ALU ops leaning on the last result
    task automatic buildAluProgram();
        int lastRd;
        int rs;
        int rt;
        int rd;
        progLen = 0;
        for (int k = 0; k < 8; k++) begin
            emit(encodeI(opAddi, (k + 7) % 8, k, int'($urandom_range(31, 0)) | (k % 2) * 16));
        end
        lastRd = 7;
        for (int k = 0; k < 24; k++) begin
            rs = ($urandom_range(1, 0) == 1) ? lastRd : int'($urandom_range(7, 0));
            rt = ($urandom_range(2, 0) == 0) ? lastRd : int'($urandom_range(7, 0));
            rd = int'($urandom_range(7, 0));
            if ($urandom_range(3, 0) == 0) emit(encodeI(opAddi, rs, rd, $urandom_range(31, 0)));
            else emit(encodeR(rs, rt, rd, functW'($urandom_range(3, 0))));
            lastRd = rd;
        end
        emit(encodeI(opHalt, 0, 0, 0));
    endtask

    // Load under reset, release, wait for halted with a cycle limit, then settle and check
    task automatic runProgram(input string name);
        int steps;
        int cycles;
        steps  = runModel(1000);
        cycles = 0;
        @(posedge clk);
        #1 rstN = 1'b0;
        for (int k = 0; k < progLen; k++) begin
            imemWe   = 1'b1;
            imemAddr = wordW'(k);
            imemData = progMem[k];
            @(posedge clk);
            #1;
        end
        imemWe = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
        checking = 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 6 * steps + 20) begin
                $display("Timeout: %s did not halt within %0d cycles", name, 6 * steps + 20);
                reportFail();
            end
        end
        repeat (4) @(posedge clk);                   // Room for stray writes after HALT
        #1 checkEnd(name, halted, err);
        checking = 1'b0;
    endtask

    // Outputs settle after the rising edge, sampled mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            if (wbValid === 1'b1) checkRegWrite(wbReg, wbData);
            if (stValid === 1'b1) checkStore(stAddr, stData);
        end
    end

    initial begin
        rstN      = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        checking  = 1'b0;
        progLen   = 0;
        void'($urandom(32'h01f90f1d));
        repeat (3) begin
            buildAluProgram();
            runProgram("random ALU");
        end
        progLen = 0;
        emit(encodeI(opAddi, 0, 1, 5));              // r1 = 5
        emit(encodeI(opAddi, 0, 2, -3));             // r2 = fffd
        emit(encodeI(opSt, 1, 2, 0));                // [5] = r2
        emit(encodeI(opLd, 1, 3, 0));                // Same address right after the store
        emit(encodeI(opSt, 1, 1, 3));                // [8] = r1
        emit(encodeI(opLd, 1, 4, 3));
        emit(encodeR(3, 4, 5, fnAdd));               // Load-use stall
        emit(encodeI(opSt, 2, 5, -1));               // Address fffc, wraps in dmem
        emit(encodeI(opAddi, 0, 6, -4));
        emit(encodeI(opLd, 6, 7, 0));
        emit(encodeI(opLd, 1, 6, 3));                // Other address, older store
        emit(encodeI(opHalt, 0, 0, 0));
        runProgram("load store");
        progLen = 0;
        emit(encodeI(opAddi, 0, 1, 1));
        emit(encodeI(opBeqz, 1, 0, 3));              // Not taken, waits on r1
        emit(encodeI(opAddi, 0, 2, 7));
        emit(encodeI(opBeqz, 0, 0, 3));              // Taken to 7
        emit(encodeI(opAddi, 0, 3, 9));              // Wrong path from here to 6
        emit(encodeI(opSt, 0, 2, 0));
        emit(encodeI(opAddi, 0, 4, 11));
        emit(encodeI(opAddi, 2, 5, 1));              // Branch target
        emit(encodeI(opAddi, 0, 7, 2));              // Loop count
        emit(encodeI(opAddi, 7, 7, -1));
        emit(encodeI(opSt, 0, 7, 15));
        emit(encodeI(opBeqz, 7, 0, 1));              // Exit to HALT
        emit(encodeI(opBeqz, 0, 0, -4));             // Back to 9, flushes a decoded HALT
        emit(encodeI(opHalt, 0, 0, 0));
        emit(encodeI(opAddi, 0, 1, 15));
        runProgram("branch");
        progLen = 0;
        emit(encodeI(opAddi, 0, 1, 3));
        emit(encodeR(1, 1, 2, fnAdd));
        emit(encodeI(opHalt, 0, 0, 0));
        emit(encodeI(opAddi, 0, 3, 1));              // Must never retire
        emit(encodeI(opSt, 0, 2, 0));
        emit(encodeI(opHalt, 0, 0, 0));
        runProgram("halt");
        progLen = 0;
        emit(encodeI(opAddi, 0, 1, 6));
        emit(encodeI(5'b11111, 1, 1, 0));            // Illegal
        emit(encodeR(1, 1, 2, fnAdd));
        emit(encodeI(5'b00010, 2, 2, 7));            // Illegal
        emit(encodeI(opSt, 1, 2, 1));
        emit(encodeI(opLd, 1, 3, 1));
        emit(encodeR(3, 1, 4, fnAndn));
        emit(encodeI(opHalt, 0, 0, 0));
        runProgram("illegal opcode");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verification
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/proc.sv
verification/clockGen.sv
verification/tbProc.sv
